// ==== logic/imuldiv_defines.svh ====
/*
  widths and counts shared by the multiply/divide RTL
  both engines run one step per operand bit
*/

`ifndef IMULDIV_DEFINES_SVH
`define IMULDIV_DEFINES_SVH

// operand width
`define IMULDIV_XLEN 32

// request id width, echoed on the response
`define IMULDIV_ID_W 4

// iterations per multiply or divide
`define IMULDIV_STEPS `IMULDIV_XLEN

// multiplier, divider and zero-divisor slot
`define IMULDIV_NUM_PEERS 3

`endif

// ==== logic/imuldiv_pkg.sv ====
/*
  op encoding, request and response structs, result union
  result word is read as a 64-bit product or as remainder/quotient
*/

`include "imuldiv_defines.svh"

package imuldiv_pkg;

  // --------------------
  // op encoding
  // --------------------
  typedef enum logic [1:0] {
    mul_signed   = 2'd0,
    mul_unsigned = 2'd1,
    div_signed   = 2'd2,
    div_unsigned = 2'd3
  } imuldiv_op_e;

  // request word, 70 bits
  typedef struct packed {
    imuldiv_op_e               op;
    logic [`IMULDIV_ID_W-1:0]  id;
    logic [`IMULDIV_XLEN-1:0]  a;
    logic [`IMULDIV_XLEN-1:0]  b;
  } imuldiv_req_t;

  // --------------------
  // result views
  // --------------------
  // remainder in the upper half, quotient in the lower
  typedef struct packed {
    logic [`IMULDIV_XLEN-1:0] rem;
    logic [`IMULDIV_XLEN-1:0] quo;
  } imuldiv_divres_t;

  typedef union packed {
    logic [2*`IMULDIV_XLEN-1:0] product;
    imuldiv_divres_t            divide;
  } imuldiv_result_u;

  // response word, 70 bits
  typedef struct packed {
    logic [`IMULDIV_ID_W-1:0] id;
    imuldiv_op_e              op;
    imuldiv_result_u          result;
  } imuldiv_resp_t;

endpackage

// ==== logic/imuldiv_req_dispatch.sv ====
/*
  steers each request to the multiplier, the divider or the zero-divisor slot
  the slot holds one by-zero answer and accepts only while empty
*/

`timescale 1ns/1ps

module imuldiv_req_dispatch (
  input  logic                       clk,
  input  logic                       reset,
  input  imuldiv_pkg::imuldiv_req_t  req,
  input  logic                       req_val,
  output logic                       req_rdy,
  output logic                       mul_req_val,
  input  logic                       mul_req_rdy,
  output logic                       div_req_val,
  input  logic                       div_req_rdy,
  output imuldiv_pkg::imuldiv_resp_t zero_resp,
  output logic                       zero_resp_val,
  input  logic                       zero_resp_rdy
);

  logic is_div;
  logic b_zero;
  logic zero_hit;
  logic zero_load;

  // --------------------
  // op decode
  // --------------------
  assign is_div = (req.op == imuldiv_pkg::div_signed) ||
                  (req.op == imuldiv_pkg::div_unsigned);
  assign b_zero = (req.b == '0);

  // divide by zero never reaches the divider
  assign mul_req_val = req_val && !is_div;
  assign div_req_val = req_val && is_div && !b_zero;
  assign zero_hit    = req_val && is_div && b_zero;

  // ready of whichever target the op picks
  assign req_rdy = !is_div ? mul_req_rdy :
                   b_zero  ? !zero_resp_val : div_req_rdy;

  assign zero_load = zero_hit && !zero_resp_val;

  // --------------------
  // zero-divisor slot
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      zero_resp_val <= 1'b0;
    end else if (zero_load) begin
      zero_resp_val <= 1'b1;
    end else if (zero_resp_val && zero_resp_rdy) begin
      zero_resp_val <= 1'b0;
    end
  end

  // quotient all ones, remainder is the dividend, signed or not
  always_ff @(posedge clk) begin
    if (zero_load) begin
      zero_resp.id                 <= req.id;
      zero_resp.op                 <= req.op;
      zero_resp.result.divide.rem  <= req.a;
      zero_resp.result.divide.quo  <= '1;
    end
  end

  // a stalled request keeps its valid and data until it is taken
  assert property (@(posedge clk) disable iff (reset)
    (req_val && !req_rdy) |=> (req_val && $stable(req)));

endmodule

// ==== logic/imuldiv_int_mul_iterative.sv ====
/*
  shift-add multiplier, one partial product per cycle, 64-bit full result
  accepts only when idle; response valid 34 cycles after acceptance
*/

`timescale 1ns/1ps
`include "imuldiv_defines.svh"

module imuldiv_int_mul_iterative (
  input  logic                       clk,
  input  logic                       reset,
  input  imuldiv_pkg::imuldiv_req_t  req,
  input  logic                       req_val,
  output logic                       req_rdy,
  output imuldiv_pkg::imuldiv_resp_t resp,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  localparam int CNT_W = $clog2(`IMULDIV_STEPS + 1);

  typedef enum logic [1:0] {s_idle, s_calc, s_fixup, s_done} state_e;

  state_e                       state;
  logic [CNT_W-1:0]             count;
  logic                         is_signed;
  logic [`IMULDIV_XLEN-1:0]     a_mag;
  logic [`IMULDIV_XLEN-1:0]     b_mag;
  logic [`IMULDIV_XLEN-1:0]     a_shift;
  logic [2*`IMULDIV_XLEN-1:0]   mcand;
  logic [2*`IMULDIV_XLEN-1:0]   prod;
  logic                         neg_prod;
  logic                         accept;
  logic                         deliver;

  assign req_rdy  = (state == s_idle);
  assign resp_val = (state == s_done);
  assign accept   = req_val && req_rdy;
  assign deliver  = resp_val && resp_rdy;

  // magnitudes for signed ops, raw operands otherwise
  assign is_signed = (req.op == imuldiv_pkg::mul_signed);
  assign a_mag = (is_signed && req.a[`IMULDIV_XLEN-1]) ? -req.a : req.a;
  assign b_mag = (is_signed && req.b[`IMULDIV_XLEN-1]) ? -req.b : req.b;

  // --------------------
  // control
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= s_idle;
      count <= '0;
    end else begin
      case (state)
        s_idle: begin
          if (accept) begin
            state <= s_calc;
            count <= '0;
          end
        end
        s_calc: begin
          count <= count + 1'b1;
          // last of the 32 steps
          if (count == CNT_W'(`IMULDIV_STEPS - 1)) state <= s_fixup;
        end
        s_fixup: state <= s_done;
        default: begin
          if (deliver) state <= s_idle;
        end
      endcase
    end
  end

  // --------------------
  // datapath
  // --------------------
  always_ff @(posedge clk) begin
    if (accept) begin
      a_shift  <= a_mag;
      mcand    <= {{`IMULDIV_XLEN{1'b0}}, b_mag};
      prod     <= '0;
      neg_prod <= is_signed && (req.a[`IMULDIV_XLEN-1] ^ req.b[`IMULDIV_XLEN-1]);
      resp.id  <= req.id;
      resp.op  <= req.op;
    end else if (state == s_calc) begin
      // add the multiplicand where the multiplier bit is set
      if (a_shift[0]) prod <= prod + mcand;
      a_shift <= a_shift >> 1;
      mcand   <= mcand << 1;
    end
    if (state == s_fixup) begin
      resp.result.product <= neg_prod ? -prod : prod;
    end
  end

endmodule

// ==== logic/imuldiv_int_div_iterative.sv ====
/*
  restoring divider, one quotient bit per cycle; zero divisors are not expected here
  quotient negated on differing signs, remainder follows the dividend, overflow wraps
*/

`timescale 1ns/1ps
`include "imuldiv_defines.svh"

module imuldiv_int_div_iterative (
  input  logic                       clk,
  input  logic                       reset,
  input  imuldiv_pkg::imuldiv_req_t  req,
  input  logic                       req_val,
  output logic                       req_rdy,
  output imuldiv_pkg::imuldiv_resp_t resp,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  logic rq_en;
  logic rq_sel;
  logic b_en;
  logic resp_en;

  imuldiv_int_div_iterative_ctrl ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .rq_en    (rq_en),
    .rq_sel   (rq_sel),
    .b_en     (b_en),
    .resp_en  (resp_en)
  );

  imuldiv_int_div_iterative_dpath dpath (
    .clk     (clk),
    .req     (req),
    .rq_en   (rq_en),
    .rq_sel  (rq_sel),
    .b_en    (b_en),
    .resp_en (resp_en),
    .resp    (resp)
  );

endmodule

// --------------------
// control
// --------------------
module imuldiv_int_div_iterative_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic rq_en,
  output logic rq_sel,
  output logic b_en,
  output logic resp_en
);

  localparam int CNT_W = $clog2(`IMULDIV_STEPS + 1);

  typedef enum logic [1:0] {s_idle, s_calc, s_fixup, s_done} state_e;

  state_e           state;
  logic [CNT_W-1:0] count;
  logic             accept;

  assign req_rdy  = (state == s_idle);
  assign resp_val = (state == s_done);
  assign accept   = req_val && req_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= s_idle;
      count <= '0;
    end else begin
      case (state)
        s_idle: begin
          if (accept) begin
            state <= s_calc;
            count <= '0;
          end
        end
        s_calc: begin
          count <= count + 1'b1;
          if (count == CNT_W'(`IMULDIV_STEPS - 1)) state <= s_fixup;
        end
        s_fixup: state <= s_done;
        default: begin
          // held until the arbiter takes it
          if (resp_rdy) state <= s_idle;
        end
      endcase
    end
  end

  // load on accept, step in calc, sign and publish in fixup
  assign b_en    = accept;
  assign rq_en   = accept || (state == s_calc);
  assign rq_sel  = (state == s_calc);
  assign resp_en = (state == s_fixup);

  assert property (@(posedge clk) disable iff (reset)
    count <= CNT_W'(`IMULDIV_STEPS));

endmodule

// --------------------
// datapath
// --------------------
module imuldiv_int_div_iterative_dpath (
  input  logic                       clk,
  input  imuldiv_pkg::imuldiv_req_t  req,
  input  logic                       rq_en,
  input  logic                       rq_sel,
  input  logic                       b_en,
  input  logic                       resp_en,
  output imuldiv_pkg::imuldiv_resp_t resp
);

  localparam int W = `IMULDIV_XLEN;

  logic           is_signed;
  logic [W-1:0]   a_mag;
  logic [W-1:0]   b_mag;
  // remainder in [2W:W], quotient in [W-1:0]
  logic [2*W:0]   rq_reg;
  logic [2*W:0]   divisor;
  logic [2*W:0]   shifted;
  logic [2*W:0]   diff;
  logic [2*W:0]   step_out;
  logic           neg_quo;
  logic           neg_rem;

  assign is_signed = (req.op == imuldiv_pkg::div_signed);
  assign a_mag = (is_signed && req.a[W-1]) ? -req.a : req.a;
  assign b_mag = (is_signed && req.b[W-1]) ? -req.b : req.b;

  // shift in the next dividend bit, try the subtraction
  assign shifted  = rq_reg << 1;
  assign diff     = shifted - divisor;
  // non-negative difference keeps it and sets the quotient bit
  assign step_out = diff[2*W] ? shifted : {diff[2*W:1], 1'b1};

  always_ff @(posedge clk) begin
    if (rq_en) rq_reg <= rq_sel ? step_out : {{(W+1){1'b0}}, a_mag};
    if (b_en) begin
      divisor <= {1'b0, b_mag, {W{1'b0}}};
      neg_quo <= is_signed && (req.a[W-1] ^ req.b[W-1]);
      neg_rem <= is_signed && req.a[W-1];
      resp.id <= req.id;
      resp.op <= req.op;
    end
    if (resp_en) begin
      resp.result.divide.quo <= neg_quo ? -rq_reg[W-1:0] : rq_reg[W-1:0];
      resp.result.divide.rem <= neg_rem ? -rq_reg[2*W-1:W] : rq_reg[2*W-1:W];
    end
  end

endmodule

// ==== logic/imuldiv_resp_arbiter.sv ====
/*
  round-robin over multiplier, divider and zero slot onto one response bus
  grant is locked while a response waits on back-pressure
*/

`timescale 1ns/1ps
`include "imuldiv_defines.svh"

module imuldiv_resp_arbiter (
  input  logic                       clk,
  input  logic                       reset,
  input  imuldiv_pkg::imuldiv_resp_t mul_resp,
  input  logic                       mul_resp_val,
  output logic                       mul_resp_rdy,
  input  imuldiv_pkg::imuldiv_resp_t div_resp,
  input  logic                       div_resp_val,
  output logic                       div_resp_rdy,
  input  imuldiv_pkg::imuldiv_resp_t zero_resp,
  input  logic                       zero_resp_val,
  output logic                       zero_resp_rdy,
  output imuldiv_pkg::imuldiv_resp_t resp,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  logic [`IMULDIV_NUM_PEERS-1:0] vals;
  logic [1:0]                    ptr;
  logic [1:0]                    rr_idx;
  logic [1:0]                    sel_idx;
  logic [1:0]                    held_idx;
  logic                          locked;
  logic                          found;
  int                            cand;

  // peer index 0 mul, 1 div, 2 zero slot
  assign vals = {zero_resp_val, div_resp_val, mul_resp_val};

  // first valid peer at or after the pointer
  always_comb begin
    rr_idx = ptr;
    found  = 1'b0;
    cand   = 0;
    for (int i = 0; i < `IMULDIV_NUM_PEERS; i++) begin
      cand = (int'(ptr) + i) % `IMULDIV_NUM_PEERS;
      if (!found && vals[cand]) begin
        found  = 1'b1;
        rr_idx = cand[1:0];
      end
    end
  end

  // a stalled grant is kept even if another peer turns valid
  assign sel_idx  = locked ? held_idx : rr_idx;
  assign resp_val = vals[sel_idx];

  always_comb begin
    case (sel_idx)
      2'd0:    resp = mul_resp;
      2'd1:    resp = div_resp;
      default: resp = zero_resp;
    endcase
  end

  assign mul_resp_rdy  = resp_rdy && (sel_idx == 2'd0);
  assign div_resp_rdy  = resp_rdy && (sel_idx == 2'd1);
  assign zero_resp_rdy = resp_rdy && (sel_idx == 2'd2);

  // --------------------
  // pointer and lock
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      ptr      <= 2'd0;
      locked   <= 1'b0;
      held_idx <= 2'd0;
    end else if (resp_val && resp_rdy) begin
      ptr    <= (sel_idx == 2'(`IMULDIV_NUM_PEERS - 1)) ? 2'd0 : sel_idx + 2'd1;
      locked <= 1'b0;
    end else if (resp_val) begin
      locked   <= 1'b1;
      held_idx <= sel_idx;
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (sel_idx == $past(sel_idx)));

endmodule

// ==== logic/imuldiv_unit.sv ====
/*
  iterative multiply/divide unit, responses may leave out of request order
  the request id on each response identifies it
*/

`timescale 1ns/1ps

module imuldiv_unit (
  input  logic                       clk,
  input  logic                       reset,
  input  imuldiv_pkg::imuldiv_req_t  req,
  input  logic                       req_val,
  output logic                       req_rdy,
  output imuldiv_pkg::imuldiv_resp_t resp,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  logic                       mul_req_val, mul_req_rdy;
  logic                       div_req_val, div_req_rdy;
  imuldiv_pkg::imuldiv_resp_t mul_resp, div_resp, zero_resp;
  logic                       mul_resp_val, mul_resp_rdy;
  logic                       div_resp_val, div_resp_rdy;
  logic                       zero_resp_val, zero_resp_rdy;

  imuldiv_req_dispatch dispatch (
    .clk (clk), .reset (reset),
    .req (req), .req_val (req_val), .req_rdy (req_rdy),
    .mul_req_val (mul_req_val), .mul_req_rdy (mul_req_rdy),
    .div_req_val (div_req_val), .div_req_rdy (div_req_rdy),
    .zero_resp (zero_resp), .zero_resp_val (zero_resp_val),
    .zero_resp_rdy (zero_resp_rdy)
  );

  // engines see the request unchanged
  imuldiv_int_mul_iterative mul (
    .clk (clk), .reset (reset),
    .req (req), .req_val (mul_req_val), .req_rdy (mul_req_rdy),
    .resp (mul_resp), .resp_val (mul_resp_val), .resp_rdy (mul_resp_rdy)
  );

  imuldiv_int_div_iterative div (
    .clk (clk), .reset (reset),
    .req (req), .req_val (div_req_val), .req_rdy (div_req_rdy),
    .resp (div_resp), .resp_val (div_resp_val), .resp_rdy (div_resp_rdy)
  );

  imuldiv_resp_arbiter arbiter (
    .clk (clk), .reset (reset),
    .mul_resp (mul_resp), .mul_resp_val (mul_resp_val), .mul_resp_rdy (mul_resp_rdy),
    .div_resp (div_resp), .div_resp_val (div_resp_val), .div_resp_rdy (div_resp_rdy),
    .zero_resp (zero_resp), .zero_resp_val (zero_resp_val),
    .zero_resp_rdy (zero_resp_rdy),
    .resp (resp), .resp_val (resp_val), .resp_rdy (resp_rdy)
  );

endmodule

// ==== tb/imuldiv_unit_tb.sv ====
/*
  testbench for the multiply/divide unit; requests and expected results come from
  tb/imuldiv_stim.txt, run from the project root, at most one line per id
*/

`timescale 1ns/1ps
`include "imuldiv_defines.svh"

module imuldiv_unit_tb;

  localparam int MAX_REQ       = 1 << `IMULDIV_ID_W;
  localparam int CLK_PERIOD    = 4;
  localparam int ENGINE_CYCLES = 34;

  logic                       clk;
  logic                       reset;
  imuldiv_pkg::imuldiv_req_t  req;
  logic                       req_val;
  logic                       req_rdy;
  imuldiv_pkg::imuldiv_resp_t resp;
  logic                       resp_val;
  logic                       resp_rdy;

  // requests in file order
  imuldiv_pkg::imuldiv_req_t    req_q[$];
  // expected values and bookkeeping by id
  imuldiv_pkg::imuldiv_result_u exp_result [MAX_REQ];
  imuldiv_pkg::imuldiv_op_e     exp_op [MAX_REQ];
  logic                         expected [MAX_REQ];
  logic                         seen [MAX_REQ];
  int                           arrival_pos [MAX_REQ];
  int                           num_req;
  int                           num_seen;
  int                           failures;
  int                           seed;
  int                           timeout_ns;
  logic                         load_done;

  imuldiv_unit dut (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------
  // helpers
  // --------------------
  task automatic stop_on_error();
    $display("Done: errors found");
    $fatal(1, "testbench stopped at the first error");
  endtask

  function automatic logic is_div(input imuldiv_pkg::imuldiv_op_e op);
    return (op == imuldiv_pkg::div_signed) || (op == imuldiv_pkg::div_unsigned);
  endfunction

  task automatic load_stimulus();
    int          fd;
    int          status;
    int          fields;
    logic [8*96-1:0] line;
    logic [31:0] op_v, id_v, a_v, b_v, hi_v, lo_v;
    imuldiv_pkg::imuldiv_req_t r;
    fd = $fopen("tb/imuldiv_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file tb/imuldiv_stim.txt");
      stop_on_error();
    end
    while (!$feof(fd)) begin
      line   = '0;
      status = $fgets(line, fd);
      // comment and blank lines do not scan as six hex fields
      fields = (status > 0) ?
               $sscanf(line, "%h %h %h %h %h %h", op_v, id_v, a_v, b_v, hi_v, lo_v) : 0;
      if (fields == 6) begin
        if (expected[id_v[`IMULDIV_ID_W-1:0]]) begin
          $display("stimulus file uses id %0d twice", id_v);
          stop_on_error();
        end
        r.op = imuldiv_pkg::imuldiv_op_e'(op_v[1:0]);
        r.id = id_v[`IMULDIV_ID_W-1:0];
        r.a  = a_v;
        r.b  = b_v;
        req_q.push_back(r);
        exp_op[r.id]             = r.op;
        exp_result[r.id].product = {hi_v, lo_v};
        expected[r.id]           = 1'b1;
      end
    end
    $fclose(fd);
    num_req = req_q.size();
    if (num_req == 0) begin
      $display("stimulus file holds no requests");
      stop_on_error();
    end
  endtask

  // hold valid and data until the edge where req_rdy is seen high
  task automatic send_request(input imuldiv_pkg::imuldiv_req_t r);
    req     <= r;
    req_val <= 1'b1;
    @(posedge clk);
    while (!req_rdy) @(posedge clk);
  endtask

  // --------------------
  // checks
  // --------------------
  task automatic compare_result(input logic [`IMULDIV_ID_W-1:0] id,
                                input imuldiv_pkg::imuldiv_result_u got,
                                input imuldiv_pkg::imuldiv_result_u exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: id %0d result %h_%h, expected %h_%h", $time, id,
               got.divide.rem, got.divide.quo, exp.divide.rem, exp.divide.quo);
      stop_on_error();
    end
  endtask

  task automatic compare_op(input logic [`IMULDIV_ID_W-1:0] id,
                            input imuldiv_pkg::imuldiv_op_e got,
                            input imuldiv_pkg::imuldiv_op_e exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: id %0d op %s, expected %s", $time, id,
               got.name(), exp.name());
      stop_on_error();
    end
  endtask

  task automatic check_response(input imuldiv_pkg::imuldiv_resp_t r);
    int idx;
    idx = int'(r.id);
    if (!expected[idx]) begin
      $display("response at %0t ns carries id %0d, which was never sent", $time, idx);
      stop_on_error();
    end
    if (seen[idx]) begin
      $display("response at %0t ns repeats id %0d", $time, idx);
      stop_on_error();
    end
    compare_op(r.id, r.op, exp_op[idx]);
    compare_result(r.id, r.result, exp_result[idx]);
    seen[idx]        = 1'b1;
    arrival_pos[idx] = num_seen;
    num_seen         = num_seen + 1;
  endtask

  // a zero divisor right behind a real divide must overtake it
  task automatic check_reorder();
    imuldiv_pkg::imuldiv_req_t prev;
    imuldiv_pkg::imuldiv_req_t cur;
    for (int i = 1; i < num_req; i++) begin
      prev = req_q[i-1];
      cur  = req_q[i];
      if (is_div(cur.op) && cur.b == '0 && is_div(prev.op) && prev.b != '0 &&
          arrival_pos[cur.id] > arrival_pos[prev.id]) begin
        $display("divide by zero id %0d did not return before divide id %0d",
                 cur.id, prev.id);
        failures = failures + 1;
      end
    end
  endtask

  // --------------------
  // response side
  // --------------------
  // random back-pressure, new value every cycle
  always @(posedge clk) begin
    int rnd;
    rnd = $random(seed);
    resp_rdy <= rnd[0];
  end

  always @(posedge clk) begin
    if (!reset && resp_val && resp_rdy) check_response(resp);
  end

  // --------------------
  // main flow
  // --------------------
  initial begin
    reset     = 1'b1;
    req       = '0;
    req_val   = 1'b0;
    resp_rdy  = 1'b0;
    seed      = 18844;
    num_req   = 0;
    num_seen  = 0;
    failures  = 0;
    load_done = 1'b0;
    for (int i = 0; i < MAX_REQ; i++) begin
      expected[i]    = 1'b0;
      seen[i]        = 1'b0;
      arrival_pos[i] = 0;
    end
    load_stimulus();
    // every request may wait out a full engine run, plus stalls and reset
    timeout_ns = (num_req * ENGINE_CYCLES + num_req * 16 + 100) * CLK_PERIOD;
    load_done  = 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    foreach (req_q[i]) send_request(req_q[i]);
    req_val <= 1'b0;
    wait (num_seen == num_req);
    @(posedge clk);
    check_reorder();
    if (failures == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      stop_on_error();
    end
  end

  initial begin
    wait (load_done);
    #(timeout_ns);
    $display("timeout: %0d of %0d responses arrived", num_seen, num_req);
    stop_on_error();
  end

endmodule

// ==== tb/imuldiv_stim.txt ====
// one request per line, all hex: op id a b expected_hi expected_lo
// op 0 mul signed, 1 mul unsigned, 2 div signed, 3 div unsigned; divides give rem hi, quo lo
1 0 00001234 00005678 00000000 06260060
1 1 ffffffff ffffffff fffffffe 00000001
0 2 fffffffd fffffff9 00000000 00000015
0 3 80000000 80000000 40000000 00000000
0 4 80000000 00000003 fffffffe 80000000
0 5 00000007 fffffffb ffffffff ffffffdd
3 6 00000064 00000007 00000002 0000000e
2 7 ffffff9c 00000007 fffffffe fffffff2
2 8 00000064 fffffff9 00000002 fffffff2
2 9 ffffff9c fffffff9 fffffffe 0000000e
2 a 80000000 ffffffff 00000000 80000000
3 b ffffffff 00000010 0000000f 0fffffff
3 c deadbeef 00000000 deadbeef ffffffff
2 d ffffff85 00000000 ffffff85 ffffffff
1 e ffffffff 00000002 00000001 fffffffe
3 f 80000000 ffffffff 80000000 00000000

// ==== flist.f ====
+incdir+logic
logic/imuldiv_pkg.sv
logic/imuldiv_req_dispatch.sv
logic/imuldiv_int_mul_iterative.sv
logic/imuldiv_int_div_iterative.sv
logic/imuldiv_resp_arbiter.sv
logic/imuldiv_unit.sv
tb/imuldiv_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile the multiply/divide unit and its testbench with Verilator, then run it
# the result is decided by searching the simulation output for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
  -f flist.f --top-module imuldiv_unit_tb \
  -Mdir obj_dir -o imuldiv_sim \
  && ./obj_dir/imuldiv_sim | tee /dev/stderr | grep -F "Done: no errors" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
